// File: conv3x3.f
+incdir+source
source/conv_types_pkg.sv
source/axil_pkg.sv
source/conv_regs.sv
source/window_multiplier.sv
source/channel_tree_adder.sv
source/conv3x3_top.sv
test/conv3x3_props.sv
test/conv3x3_tb.sv

// File: build.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	-f conv3x3.f \
	--top-module conv3x3_tb \
	-o conv3x3_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/conv3x3_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "PASS: all tests" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation did not pass, see $LOG"
	exit 1
fi

// File: test/conv3x3_tb.sv
`default_nettype none

`include "conv_cfg.svh"

module conv3x3_tb;
	import conv_types_pkg::*;
	import axil_pkg::*;

	// The tests take roughly 750 cycles.
	localparam int RUN_CYCLES     = 750;
	localparam int TIMEOUT_CYCLES = 4 * RUN_CYCLES;
	localparam int NUM_REGS       = 11;
	localparam int NUM_WINDOWS    = 200;

	logic          clk = 1'b0;
	logic          rst;
	axil_req_t     axil_req;
	axil_rsp_t     axil_rsp;
	pixel_window_t window;
	logic          window_valid;
	sample_t       result;
	logic          result_valid;

	logic [31:0]   lfsr_state;
	int            cycle = 0;
	int            mismatches = 0;
	int            failures = 0;
	string         test_name;
	weight_set_t   model_weights;
	logic          model_relu;
	sample_t       expected_q[$];
	int            due_q[$];
	logic [7:0]    unmapped [3] = '{8'h2c, 8'h42, 8'hfd};

	conv3x3_top dut (
		.clk          (clk),
		.rst          (rst),
		.axil_req     (axil_req),
		.axil_rsp     (axil_rsp),
		.window       (window),
		.window_valid (window_valid),
		.result       (result),
		.result_valid (result_valid)
	);

	always #2 clk = ~clk;

	// Galois form of x^32 + x^22 + x^2 + x + 1, shifting right.
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0])
			next = next ^ 32'h8020_0003;
		return next;
	endfunction

	function automatic logic [31:0] random_bits(input int width);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < width; i++)
		begin
			value      = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return value;
	endfunction

	// Taps are magnitudes of the given width, optionally made negative.
	function automatic pixel_window_t random_window(input int width, input logic negative);
		pixel_window_t w;
		for (int i = 0; i < `CONV_TAPS; i++)
		begin
			w.tap[i] = sample_t'(random_bits(width));
			if (negative)
				w.tap[i] = -w.tap[i] - 16'sd1;
		end
		return w;
	endfunction

	function automatic pixel_window_t filled_window(input sample_t value);
		pixel_window_t w;
		for (int i = 0; i < `CONV_TAPS; i++)
			w.tap[i] = value;
		return w;
	endfunction

	// Each Q16.16 product drops its extra fraction bits and keeps 16 bits.
	// The sum with the bias wraps modulo 2^16.
	function automatic sample_t model_result(input pixel_window_t w, input weight_set_t ws,
			input logic relu);
		int      full;
		sample_t sum;
		sum = ws.bias;
		for (int i = 0; i < `CONV_TAPS; i++)
		begin
			full = int'(signed'(w.tap[i])) * int'(signed'(ws.weight[i]));
			full = full >>> `CONV_FRAC_W;
			sum  = sum + sample_t'(full);
		end
		if (relu && sum[`CONV_DATA_W-1])
			sum = '0;
		return sum;
	endfunction

	function automatic void update_model(input logic [7:0] addr, input logic [31:0] data);
		if (addr <= 8'h20 && addr[1:0] == 2'b00)
			model_weights.weight[addr[5:2]] = data[15:0];
		else if (addr == 8'h24)
			model_weights.bias = data[15:0];
		else if (addr == 8'h28)
			model_relu = data[0];
	endfunction

	function automatic logic [31:0] register_image(input logic [7:0] addr);
		sample_t value;
		value = '0;
		if (addr <= 8'h20 && addr[1:0] == 2'b00)
			value = model_weights.weight[addr[5:2]];
		else if (addr == 8'h24)
			value = model_weights.bias;
		else if (addr == 8'h28)
			return {31'h0, model_relu};
		return 32'(value);
	endfunction

	task automatic check_equal(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (expected == actual)
		else
		begin
			mismatches++;
			$display("mismatch in %s (%s): expected %h, actual %h",
				test_name, what, expected, actual);
		end
	endtask

	task automatic report_counts();
		$display("summary: %0d mismatches, %0d other errors", mismatches, failures);
	endtask

	// Address and data go up one cycle apart, in either order.
	task automatic write_axil(input logic [7:0] addr, input logic [31:0] data,
			input logic data_first, output axil_resp_e resp);
		logic aw_left;
		logic w_left;
		aw_left = 1'b1;
		w_left  = 1'b1;
		for (int n = 0; aw_left || w_left; n++)
		begin
			@(posedge clk);
			if (axil_req.awvalid && axil_rsp.awready)
			begin
				axil_req.awvalid <= 1'b0;
				aw_left = 1'b0;
			end
			if (axil_req.wvalid && axil_rsp.wready)
			begin
				axil_req.wvalid <= 1'b0;
				w_left = 1'b0;
			end
			if (n == (data_first ? 1 : 0))
			begin
				axil_req.awaddr  <= addr;
				axil_req.awvalid <= 1'b1;
			end
			if (n == (data_first ? 0 : 1))
			begin
				axil_req.wdata  <= data;
				axil_req.wstrb  <= '1;
				axil_req.wvalid <= 1'b1;
			end
		end
		// The response is left waiting for one cycle before bready rises.
		@(posedge clk);
		while (!axil_rsp.bvalid)
			@(posedge clk);
		axil_req.bready <= 1'b1;
		@(posedge clk);
		resp = axil_rsp.bresp;
		axil_req.bready <= 1'b0;
	endtask

	task automatic read_axil(input logic [7:0] addr, output logic [31:0] data,
			output axil_resp_e resp);
		@(posedge clk);
		axil_req.araddr  <= addr;
		axil_req.arvalid <= 1'b1;
		@(posedge clk);
		while (!axil_rsp.arready)
			@(posedge clk);
		axil_req.arvalid <= 1'b0;
		@(posedge clk);
		while (!axil_rsp.rvalid)
			@(posedge clk);
		axil_req.rready <= 1'b1;
		@(posedge clk);
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		axil_req.rready <= 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		axil_resp_e resp;
		write_axil(addr, data, random_bits(1) != 0, resp);
		check_equal("bresp", 32'(OKAY), 32'(resp));
		update_model(addr, data);
	endtask

	task automatic drive_window(input pixel_window_t w, input logic valid);
		@(posedge clk);
		window       <= w;
		window_valid <= valid;
		if (valid)
		begin
			expected_q.push_back(model_result(w, model_weights, model_relu));
			due_q.push_back(cycle + 1 + `CONV_PIPE_LATENCY);
		end
	endtask

	task automatic stop_windows();
		@(posedge clk);
		window_valid <= 1'b0;
	endtask

	task automatic wait_drained();
		while (expected_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
	endtask

	task automatic relu_windows();
		for (int n = 0; n < 20; n++)
			drive_window(random_window(10, (n % 2) == 1), 1'b1);
		stop_windows();
		wait_drained();
	endtask

	always @(posedge clk)
	begin
		if (!rst && result_valid)
		begin
			assert (expected_q.size() != 0)
			else
			begin
				failures++;
				$display("error in %s: result_valid with no window outstanding", test_name);
			end
			if (expected_q.size() != 0)
			begin
				check_equal("result", 32'(expected_q.pop_front()), 32'(result));
				check_equal("result cycle", 32'(due_q.pop_front()), 32'(cycle));
			end
		end
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			report_counts();
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial
	begin
		logic [31:0]   data;
		logic [31:0]   value;
		logic [31:0]   saved_state;
		axil_resp_e    resp;
		pixel_window_t w;
		logic          valid;

		lfsr_state    = 32'h9f3b962a;
		model_weights = '0;
		model_relu    = 1'b0;
		test_name     = "reset";
		rst           = 1'b1;
		axil_req      = '0;
		window        = '0;
		window_valid  = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		repeat (4) @(posedge clk);
		for (int i = 0; i < NUM_REGS; i++)
		begin
			read_axil(8'(4 * i), data, resp);
			check_equal("reset value", 32'h0, data);
			check_equal("rresp", 32'(OKAY), 32'(resp));
		end

		test_name = "register access";
		for (int i = 0; i < NUM_REGS; i++)
		begin
			value = random_bits(32);
			write_reg(8'(4 * i), value);
			read_axil(8'(4 * i), data, resp);
			check_equal("readback", register_image(8'(4 * i)), data);
			check_equal("rresp", 32'(OKAY), 32'(resp));
		end
		for (int i = 0; i < 3; i++)
		begin
			write_axil(unmapped[i], random_bits(32), 1'b0, resp);
			check_equal("unmapped bresp", 32'(SLVERR), 32'(resp));
			read_axil(unmapped[i], data, resp);
			check_equal("unmapped rdata", 32'h0, data);
			check_equal("unmapped rresp", 32'(SLVERR), 32'(resp));
		end

		test_name = "random windows";
		for (int i = 0; i < 10; i++)
			write_reg(8'(4 * i), random_bits(16));
		write_reg(8'h28, 32'h0);
		for (int n = 0; n < NUM_WINDOWS; n++)
			drive_window(random_window(16, 1'b0), 1'b1);
		stop_windows();
		wait_drained();

		// Unit weights make the result the plain sum of the taps.
		test_name = "relu on";
		for (int i = 0; i < 9; i++)
			write_reg(8'(4 * i), 32'h0000_0100);
		write_reg(8'h24, 32'h0);
		write_reg(8'h28, 32'h1);
		saved_state = lfsr_state;
		relu_windows();
		test_name = "relu off";
		write_reg(8'h28, 32'h0);
		lfsr_state = saved_state;
		relu_windows();

		test_name = "wrap";
		for (int i = 0; i < 9; i++)
			write_reg(8'(4 * i), (i % 2 == 0) ? 32'h0000_7fff : 32'h0000_8000);
		write_reg(8'h24, 32'h0000_7f00);
		drive_window(filled_window(16'sh7fff), 1'b1);
		drive_window(filled_window(-16'sh8000), 1'b1);
		drive_window(filled_window(16'sh7f80), 1'b1);
		for (int n = 0; n < 16; n++)
			drive_window(random_window(16, 1'b0), 1'b1);
		stop_windows();
		wait_drained();

		test_name = "gaps";
		for (int n = 0; n < 60; n++)
		begin
			w     = random_window(16, 1'b0);
			valid = random_bits(1) != 0;
			drive_window(w, valid);
		end
		stop_windows();
		wait_drained();

		report_counts();
		if (mismatches == 0 && failures == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/conv3x3_props.sv
`default_nettype none

`include "conv_cfg.svh"

module conv3x3_props #(
	parameter int LATENCY = `CONV_PIPE_LATENCY
) (
	input wire logic                           clk,
	input wire logic                           rst,
	input wire logic                           window_valid,
	input wire logic                           result_valid,
	input wire logic signed [`CONV_DATA_W-1:0] result,
	input wire logic                           relu_enable,
	input wire axil_pkg::axil_req_t            axil_req,
	input wire axil_pkg::axil_rsp_t            axil_rsp
);
	import conv_types_pkg::*;

	// One multiplier register sits ahead of the adder tree.
	localparam int TREE_DEPTH = int'(ADD_STAGE_FINAL);

	initial
	begin
		assert (LATENCY == TREE_DEPTH + 1)
		else $error("latency %0d does not fit a tree of depth %0d", LATENCY, TREE_DEPTH);
	end

	valid_latency: assert property (@(posedge clk) disable iff (rst)
		result_valid == $past(window_valid, LATENCY))
	else $error("result_valid is not window_valid delayed by %0d cycles", LATENCY);

	quiet_in_reset: assert property (@(posedge clk)
		rst |-> !result_valid && !axil_rsp.bvalid && !axil_rsp.rvalid
			&& !axil_rsp.awready && !axil_rsp.wready && !axil_rsp.arready)
	else $error("a valid or ready is high during reset");

	// The output is gated combinationally, so it must hold on every cycle.
	relu_non_negative: assert property (@(posedge clk) disable iff (rst)
		relu_enable |-> !result[`CONV_DATA_W-1])
	else $error("negative result while ReLU is enabled");

	bvalid_hold: assert property (@(posedge clk) disable iff (rst)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
	else $error("write response dropped or changed before bready");

	rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		axil_rsp.rvalid && !axil_req.rready |=>
			axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
	else $error("read response dropped or changed before rready");

endmodule

bind conv3x3_top conv3x3_props props (
	.clk          (clk),
	.rst          (rst),
	.window_valid (window_valid),
	.result_valid (result_valid),
	.result       (result),
	.relu_enable  (relu_enable),
	.axil_req     (axil_req),
	.axil_rsp     (axil_rsp)
);

`default_nettype wire

// File: source/conv3x3_top.sv
`default_nettype none

`include "conv_cfg.svh"

module conv3x3_top (
	input  wire logic                          clk,
	input  wire logic                          rst,
	input  wire axil_pkg::axil_req_t           axil_req,
	output axil_pkg::axil_rsp_t                axil_rsp,
	input  wire conv_types_pkg::pixel_window_t window,
	input  wire logic                          window_valid,
	output logic signed [`CONV_DATA_W-1:0]     result,
	output logic                               result_valid
);
	import conv_types_pkg::*;

	weight_set_t  weights;
	logic         relu_enable;
	product_set_t products;
	logic         products_valid;

	conv_regs u_regs (
		.clk         (clk),
		.rst         (rst),
		.axil_req    (axil_req),
		.axil_rsp    (axil_rsp),
		.weights     (weights),
		.relu_enable (relu_enable)
	);

	window_multiplier u_multiplier (
		.clk            (clk),
		.rst            (rst),
		.window         (window),
		.window_valid   (window_valid),
		.weights        (weights),
		.products       (products),
		.products_valid (products_valid)
	);

	channel_tree_adder u_adder (
		.clk            (clk),
		.rst            (rst),
		.products       (products),
		.products_valid (products_valid),
		.bias           (weights.bias),
		.relu_enable    (relu_enable),
		.result         (result),
		.result_valid   (result_valid)
	);

endmodule

`default_nettype wire

// File: source/channel_tree_adder.sv
`default_nettype none

`include "conv_cfg.svh"

module channel_tree_adder (
	input  wire logic                           clk,
	input  wire logic                           rst,
	input  wire conv_types_pkg::product_set_t   products,
	input  wire logic                           products_valid,
	input  wire logic signed [`CONV_DATA_W-1:0] bias,
	input  wire logic                           relu_enable,
	output logic signed [`CONV_DATA_W-1:0]      result,
	output logic                                result_valid
);
	import conv_types_pkg::*;

	localparam int TREE_DEPTH = int'(ADD_STAGE_FINAL);

	// The last tap is paired with the bias at the first level.
	// That sum then rides along untouched until the final add.
	typedef struct packed {
		sample_t       tap_bias;
		sample_t [3:0] pair;
	} pair_stage_t;

	typedef struct packed {
		sample_t       tap_bias;
		sample_t [1:0] quad;
	} quad_stage_t;

	typedef struct packed {
		sample_t tap_bias;
		sample_t taps;
	} final_stage_t;

	pair_stage_t            pair_d;
	pair_stage_t            pair_q;
	quad_stage_t            quad_d;
	quad_stage_t            quad_q;
	final_stage_t           final_d;
	final_stage_t           final_q;
	sample_t                tree_sum;
	logic [TREE_DEPTH-1:0]  valid_pipe;

	// All sums wrap at the sample width.
	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			pair_d.pair[i] = products.product[2*i] + products.product[2*i+1];
		end
		pair_d.tap_bias = products.product[`CONV_TAPS-1] + bias;

		quad_d.quad[0]  = pair_q.pair[0] + pair_q.pair[1];
		quad_d.quad[1]  = pair_q.pair[2] + pair_q.pair[3];
		quad_d.tap_bias = pair_q.tap_bias;

		final_d.taps     = quad_q.quad[0] + quad_q.quad[1];
		final_d.tap_bias = quad_q.tap_bias;
	end

	always_ff @(posedge clk)
	begin
		pair_q  <= pair_d;
		quad_q  <= quad_d;
		final_q <= final_d;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			valid_pipe <= '0;
		else
			valid_pipe <= {valid_pipe[TREE_DEPTH-2:0], products_valid};
	end

	assign tree_sum     = final_q.taps + final_q.tap_bias;
	assign result       = (relu_enable && tree_sum[`CONV_DATA_W-1]) ? '0 : tree_sum;
	assign result_valid = valid_pipe[TREE_DEPTH-1];

endmodule

`default_nettype wire

// File: source/window_multiplier.sv
`default_nettype none

`include "conv_cfg.svh"

module window_multiplier (
	input  wire logic                          clk,
	input  wire logic                          rst,
	input  wire conv_types_pkg::pixel_window_t window,
	input  wire logic                          window_valid,
	input  wire conv_types_pkg::weight_set_t   weights,
	output conv_types_pkg::product_set_t       products,
	output logic                               products_valid
);
	import conv_types_pkg::*;

	logic signed [2*`CONV_DATA_W-1:0] full_prod   [`CONV_TAPS];
	logic signed [2*`CONV_DATA_W-1:0] scaled_prod [`CONV_TAPS];
	product_set_t                     products_d;

	// A Q8.8 by Q8.8 product is Q16.16.
	// Shifting out the extra fraction bits and keeping the low half gives Q8.8 again.
	always_comb
	begin
		for (int i = 0; i < `CONV_TAPS; i++)
		begin
			full_prod[i]          = signed'(window.tap[i]) * signed'(weights.weight[i]);
			scaled_prod[i]        = full_prod[i] >>> `CONV_FRAC_W;
			products_d.product[i] = scaled_prod[i][`CONV_DATA_W-1:0];
		end
	end

	always_ff @(posedge clk)
	begin
		products <= products_d;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			products_valid <= 1'b0;
		else
			products_valid <= window_valid;
	end

endmodule

`default_nettype wire

// File: source/conv_regs.sv
`default_nettype none

`include "conv_cfg.svh"

module conv_regs (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire axil_pkg::axil_req_t    axil_req,
	output axil_pkg::axil_rsp_t         axil_rsp,
	output conv_types_pkg::weight_set_t weights,
	output logic                        relu_enable
);
	import axil_pkg::*;
	import conv_types_pkg::*;

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_COLLECT,
		WR_RESP
	} wr_state_e;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_RESP
	} rd_state_e;

	wr_state_e  wr_state;
	rd_state_e  rd_state;
	logic       aw_done;
	logic       w_done;
	logic       aw_ready;
	logic       w_ready;
	logic       ar_ready;
	logic       aw_hs;
	logic       w_hs;
	logic       ar_hs;
	logic       b_hs;
	logic       r_hs;
	logic       wr_commit;
	axil_addr_t wr_addr;
	sample_t    wr_data;
	axil_resp_e bresp_q;
	axil_resp_e rresp_q;
	axil_data_t rdata_q;

	function automatic logic addr_mapped(input axil_addr_t addr);
		case (conv_reg_e'(addr))
			WEIGHT0, WEIGHT1, WEIGHT2, WEIGHT3, WEIGHT4,
			WEIGHT5, WEIGHT6, WEIGHT7, WEIGHT8, BIAS, CTRL:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic axil_data_t sign_extend(input sample_t value);
		return {{(`CONV_AXIL_DATA_W-`CONV_DATA_W){value[`CONV_DATA_W-1]}}, value};
	endfunction

	function automatic axil_data_t read_value(input axil_addr_t addr);
		axil_data_t data;
		data = '0;
		case (conv_reg_e'(addr))
			WEIGHT0, WEIGHT1, WEIGHT2, WEIGHT3, WEIGHT4,
			WEIGHT5, WEIGHT6, WEIGHT7, WEIGHT8:
				data = sign_extend(weights.weight[addr[5:2]]);
			BIAS:
				data = sign_extend(weights.bias);
			CTRL:
				data[0] = relu_enable;
			default:
				data = '0;
		endcase
		return data;
	endfunction

	// Address and data are taken independently; the write fires once both are in.
	assign aw_ready  = (wr_state == WR_COLLECT) && !aw_done;
	assign w_ready   = (wr_state == WR_COLLECT) && !w_done;
	assign ar_ready  = (rd_state == RD_ADDR);
	assign aw_hs     = axil_req.awvalid && aw_ready;
	assign w_hs      = axil_req.wvalid && w_ready;
	assign ar_hs     = axil_req.arvalid && ar_ready;
	assign b_hs      = axil_req.bready && (wr_state == WR_RESP);
	assign r_hs      = axil_req.rready && (rd_state == RD_RESP);
	assign wr_commit = (wr_state == WR_COLLECT) && aw_done && w_done;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wr_state <= WR_IDLE;
			aw_done  <= 1'b0;
			w_done   <= 1'b0;
		end
		else
		begin
			case (wr_state)
				WR_IDLE:
				begin
					aw_done  <= 1'b0;
					w_done   <= 1'b0;
					wr_state <= WR_COLLECT;
				end
				WR_COLLECT:
				begin
					if (aw_hs)
						aw_done <= 1'b1;
					if (w_hs)
						w_done <= 1'b1;
					if (wr_commit)
						wr_state <= WR_RESP;
				end
				WR_RESP:
				begin
					if (b_hs)
						wr_state <= WR_IDLE;
				end
				default:
					wr_state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			rd_state <= RD_IDLE;
		else
		begin
			case (rd_state)
				RD_IDLE:
					rd_state <= RD_ADDR;
				RD_ADDR:
				begin
					if (ar_hs)
						rd_state <= RD_RESP;
				end
				RD_RESP:
				begin
					if (r_hs)
						rd_state <= RD_IDLE;
				end
				default:
					rd_state <= RD_IDLE;
			endcase
		end
	end

	// Only the low half of the write data is kept.
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			weights     <= '0;
			relu_enable <= 1'b0;
		end
		else if (wr_commit)
		begin
			case (conv_reg_e'(wr_addr))
				WEIGHT0, WEIGHT1, WEIGHT2, WEIGHT3, WEIGHT4,
				WEIGHT5, WEIGHT6, WEIGHT7, WEIGHT8:
					weights.weight[wr_addr[5:2]] <= wr_data;
				BIAS:
					weights.bias <= wr_data;
				CTRL:
					relu_enable <= wr_data[0];
				default:
					;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (aw_hs)
			wr_addr <= axil_req.awaddr;
		if (w_hs)
			wr_data <= axil_req.wdata[`CONV_DATA_W-1:0];
		if (wr_commit)
			bresp_q <= addr_mapped(wr_addr) ? OKAY : SLVERR;
		if (ar_hs)
		begin
			rdata_q <= read_value(axil_req.araddr);
			rresp_q <= addr_mapped(axil_req.araddr) ? OKAY : SLVERR;
		end
	end

	always_comb
	begin
		axil_rsp.awready = aw_ready;
		axil_rsp.wready  = w_ready;
		axil_rsp.bresp   = bresp_q;
		axil_rsp.bvalid  = (wr_state == WR_RESP);
		axil_rsp.arready = ar_ready;
		axil_rsp.rdata   = rdata_q;
		axil_rsp.rresp   = rresp_q;
		axil_rsp.rvalid  = (rd_state == RD_RESP);
	end

endmodule

`default_nettype wire

// File: source/axil_pkg.sv
`default_nettype none

`include "conv_cfg.svh"

package axil_pkg;

	typedef logic [`CONV_AXIL_ADDR_W-1:0] axil_addr_t;
	typedef logic [`CONV_AXIL_DATA_W-1:0] axil_data_t;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axil_resp_e;

	// Fields driven by the master.
	typedef struct packed {
		axil_addr_t                     awaddr;
		logic                           awvalid;
		axil_data_t                     wdata;
		logic [`CONV_AXIL_DATA_W/8-1:0] wstrb;
		logic                           wvalid;
		logic                           bready;
		axil_addr_t                     araddr;
		logic                           arvalid;
		logic                           rready;
	} axil_req_t;

	// Fields driven by the slave.
	typedef struct packed {
		logic       awready;
		logic       wready;
		axil_resp_e bresp;
		logic       bvalid;
		logic       arready;
		axil_data_t rdata;
		axil_resp_e rresp;
		logic       rvalid;
	} axil_rsp_t;

	// Register map. Bit 0 of CTRL enables ReLU.
	typedef enum logic [`CONV_AXIL_ADDR_W-1:0] {
		WEIGHT0 = 8'h00,
		WEIGHT1 = 8'h04,
		WEIGHT2 = 8'h08,
		WEIGHT3 = 8'h0c,
		WEIGHT4 = 8'h10,
		WEIGHT5 = 8'h14,
		WEIGHT6 = 8'h18,
		WEIGHT7 = 8'h1c,
		WEIGHT8 = 8'h20,
		BIAS    = 8'h24,
		CTRL    = 8'h28
	} conv_reg_e;

endpackage

`default_nettype wire

// File: source/conv_types_pkg.sv
`default_nettype none

`include "conv_cfg.svh"

package conv_types_pkg;

	typedef logic signed [`CONV_DATA_W-1:0] sample_t;

	// Tap 0 is the top left pixel and tap 8 the bottom right one.
	typedef struct packed {
		sample_t [`CONV_TAPS-1:0] tap;
	} pixel_window_t;

	// Weights use the same tap order as the window.
	typedef struct packed {
		sample_t                  bias;
		sample_t [`CONV_TAPS-1:0] weight;
	} weight_set_t;

	// Products already rescaled back to Q8.8.
	typedef struct packed {
		sample_t [`CONV_TAPS-1:0] product;
	} product_set_t;

	// Levels of the adder tree.
	// The value of the last level is the tree's register depth.
	typedef enum logic [1:0] {
		ADD_STAGE_INPUT = 2'd0,
		ADD_STAGE_PAIR  = 2'd1,
		ADD_STAGE_QUAD  = 2'd2,
		ADD_STAGE_FINAL = 2'd3
	} adder_stage_e;

endpackage

`default_nettype wire

// File: source/conv_cfg.svh
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// Samples, weights and the bias are signed Q8.8.
`define CONV_DATA_W 16
`define CONV_FRAC_W 8

// A 3x3 window, stored row-major.
`define CONV_TAPS 9

`define CONV_AXIL_ADDR_W 8
`define CONV_AXIL_DATA_W 32

// One multiplier stage and three adder stages.
`define CONV_PIPE_LATENCY 4

`endif
